// ==== hw/ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data path
`define EX_XLEN 64
`define EX_WORD 32

// register file index
`define EX_REG_AW 5

// instruction word
`define EX_INS_W 32

// branch offset bits 12:1 with bit 0 implied zero
`define EX_BIMM_W 12

`endif

// ==== hw/ex_op_pkg.sv ====
package ex_op_pkg;

	typedef enum logic [4:0] {
		op_add   = 5'd0,
		op_addw  = 5'd1,
		op_sll   = 5'd2,
		op_sllw  = 5'd3,
		op_sra   = 5'd4,
		op_sraw  = 5'd5,
		op_srl   = 5'd6,
		op_srlw  = 5'd7,
		op_and   = 5'd8,
		op_or    = 5'd9,
		op_xor   = 5'd10,
		op_slt   = 5'd11,
		op_sltu  = 5'd12,
		op_eq    = 5'd13,
		op_ne    = 5'd14,
		op_sge   = 5'd15,
		op_sgeu  = 5'd16,
		op_sub   = 5'd17,
		op_subw  = 5'd18,
		op_mul   = 5'd19, // low 64 bits
		op_mulh  = 5'd20, // high half of signed x signed
		op_mulhu = 5'd21, // high half of unsigned x unsigned
		op_mulw  = 5'd22
	} alu_op_t;

	typedef enum logic [1:0] {
		mul_lo    = 2'd0,
		mul_hi_ss = 2'd1,
		mul_hi_uu = 2'd2,
		mul_word  = 2'd3 // sign-extended low word
	} mul_kind_t;

endpackage

// ==== hw/ex_pipe_pkg.sv ====
`include "ex_cfg.svh"

package ex_pipe_pkg;

	// decode fields for the mem and wb stages
	typedef struct packed {
		logic                  branch;
		logic                  mem_w_en;
		logic                  wb_sel; // 0 result, 1 load data
		logic                  reg_w_en;
		logic [`EX_REG_AW-1:0] rdest;
	} ex_ctrl_t;

	typedef struct packed {
		logic [`EX_XLEN-1:0]   pc;
		logic [`EX_INS_W-1:0]  ins;
		ex_op_pkg::alu_op_t    op;
		logic [`EX_XLEN-1:0]   src_a;
		logic [`EX_XLEN-1:0]   src_b;
		logic [`EX_XLEN-1:0]   rt_data; // store data
		logic [`EX_BIMM_W-1:0] bimm;
		ex_ctrl_t              ctrl;
	} ex_req_t;

	typedef struct packed {
		logic [`EX_XLEN-1:0]   pc;
		logic [`EX_INS_W-1:0]  ins;
		logic                  mem_w_en;
		logic                  wb_sel;
		logic                  reg_w_en;
		logic [`EX_REG_AW-1:0] rdest;
		logic [`EX_XLEN-1:0]   rt_data;
		logic [`EX_XLEN-1:0]   result;
		logic                  branch_taken;
		logic [`EX_XLEN-1:0]   branch_target;
	} ex_rsp_t;

endpackage

// ==== hw/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu (
	input  ex_op_pkg::alu_op_t   op,
	input  logic [`EX_XLEN-1:0]  src_a,
	input  logic [`EX_XLEN-1:0]  src_b,
	output logic [`EX_XLEN-1:0]  result
);

	localparam int sh_w  = $clog2(`EX_XLEN);
	localparam int shw_w = $clog2(`EX_WORD);

	function automatic logic [`EX_XLEN-1:0] sext_w(input logic [`EX_WORD-1:0] v);
		return {{(`EX_XLEN - `EX_WORD){v[`EX_WORD-1]}}, v};
	endfunction

	always_comb begin
		case (op)
			ex_op_pkg::op_add: begin
				result = src_a + src_b;
			end
			ex_op_pkg::op_addw: begin
				result = sext_w(src_a[`EX_WORD-1:0] + src_b[`EX_WORD-1:0]);
			end
			ex_op_pkg::op_sll: begin
				result = src_a << src_b[sh_w-1:0];
			end
			ex_op_pkg::op_sllw: begin
				result = sext_w(src_a[`EX_WORD-1:0] << src_b[shw_w-1:0]);
			end
			ex_op_pkg::op_sra: begin
				result = $signed(src_a) >>> src_b[sh_w-1:0];
			end
			ex_op_pkg::op_sraw: begin
				result = sext_w($signed(src_a[`EX_WORD-1:0]) >>> src_b[shw_w-1:0]);
			end
			ex_op_pkg::op_srl: begin
				result = src_a >> src_b[sh_w-1:0];
			end
			ex_op_pkg::op_srlw: begin
				result = sext_w(src_a[`EX_WORD-1:0] >> src_b[shw_w-1:0]); // bit 31 may be set
			end
			ex_op_pkg::op_and: begin
				result = src_a & src_b;
			end
			ex_op_pkg::op_or: begin
				result = src_a | src_b;
			end
			ex_op_pkg::op_xor: begin
				result = src_a ^ src_b;
			end
			ex_op_pkg::op_slt: begin
				result = `EX_XLEN'($signed(src_a) < $signed(src_b));
			end
			ex_op_pkg::op_sltu: begin
				result = `EX_XLEN'(src_a < src_b);
			end
			ex_op_pkg::op_eq: begin
				result = `EX_XLEN'(src_a == src_b); // beq
			end
			ex_op_pkg::op_ne: begin
				result = `EX_XLEN'(src_a != src_b);
			end
			ex_op_pkg::op_sge: begin
				result = `EX_XLEN'($signed(src_a) >= $signed(src_b));
			end
			ex_op_pkg::op_sgeu: begin
				result = `EX_XLEN'(src_a >= src_b);
			end
			ex_op_pkg::op_sub: begin
				result = src_a - src_b;
			end
			ex_op_pkg::op_subw: begin
				result = sext_w(src_a[`EX_WORD-1:0] - src_b[`EX_WORD-1:0]);
			end
			default: begin
				result = '0; // multiplies come from ex_mul
			end
		endcase
	end

endmodule

// ==== hw/ex_mul.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mul (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  ex_op_pkg::mul_kind_t   kind,
	input  logic [`EX_XLEN-1:0]    a,
	input  logic [`EX_XLEN-1:0]    b,
	output logic                   busy,
	output logic                   done,
	output logic [`EX_XLEN-1:0]    product
);

	localparam int cnt_w = $clog2(`EX_XLEN + 1);

	logic [`EX_XLEN-1:0]   op_a;
	logic [`EX_XLEN-1:0]   op_b;
	logic                  sgn;
	logic [`EX_XLEN-1:0]   mag_a;
	logic [`EX_XLEN-1:0]   mag_b;
	logic [2*`EX_XLEN-1:0] mcand;
	logic [`EX_XLEN-1:0]   mplier;
	logic [2*`EX_XLEN-1:0] acc;
	logic [2*`EX_XLEN-1:0] full;
	logic                  neg_q;
	ex_op_pkg::mul_kind_t  kind_q;
	logic [cnt_w-1:0]      cnt;
	logic                  last;
	logic                  load;

	// operand conditioning
	always_comb begin
		op_a = a;
		op_b = b;
		sgn = 1'b0;
		case (kind)
			ex_op_pkg::mul_hi_ss: begin
				sgn = 1'b1;
			end
			ex_op_pkg::mul_word: begin
				op_a = {{(`EX_XLEN - `EX_WORD){a[`EX_WORD-1]}}, a[`EX_WORD-1:0]};
				op_b = {{(`EX_XLEN - `EX_WORD){b[`EX_WORD-1]}}, b[`EX_WORD-1:0]};
				sgn = 1'b1;
			end
			default: begin
				sgn = 1'b0; // low half is sign-agnostic
			end
		endcase
		mag_a = (sgn && op_a[`EX_XLEN-1]) ? -op_a : op_a;
		mag_b = (sgn && op_b[`EX_XLEN-1]) ? -op_b : op_b;
	end

	assign load = start && !busy;
	assign last = busy && (cnt == cnt_w'(`EX_XLEN));
	assign full = neg_q ? -acc : acc;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt <= '0;
		end else begin
			done <= last;
			if (load) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (last) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// one partial product per cycle
	always_ff @(posedge clk) begin
		if (load) begin
			mcand <= {{`EX_XLEN{1'b0}}, mag_a};
			mplier <= mag_b;
			acc <= '0;
			neg_q <= sgn && (op_a[`EX_XLEN-1] ^ op_b[`EX_XLEN-1]);
			kind_q <= kind;
		end else if (busy && !last) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	// held until the next start
	always_ff @(posedge clk) begin
		if (last) begin
			case (kind_q)
				ex_op_pkg::mul_lo:    product <= full[`EX_XLEN-1:0];
				ex_op_pkg::mul_word:  product <= {{(`EX_XLEN - `EX_WORD){full[`EX_WORD-1]}},
				                                  full[`EX_WORD-1:0]};
				default:              product <= full[2*`EX_XLEN-1:`EX_XLEN];
			endcase
		end
	end

endmodule

// ==== hw/ex_issue.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_issue (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  ex_pipe_pkg::ex_req_t   in_req,
	output logic                   wr_valid,
	input  logic                   wr_ready,
	output ex_pipe_pkg::ex_rsp_t   wr_rsp
);

	ex_pipe_pkg::ex_req_t  req_q; // held while multiplying
	ex_pipe_pkg::ex_req_t  cur;
	ex_op_pkg::mul_kind_t  mul_kind;
	logic                  is_mul;
	logic                  mul_active;
	logic                  mul_held; // product waits for buffer room
	logic                  mul_start;
	logic                  mul_busy;
	logic                  mul_done;
	logic [`EX_XLEN-1:0]   alu_result;
	logic [`EX_XLEN-1:0]   mul_product;
	logic [`EX_XLEN-1:0]   result;
	logic [`EX_XLEN-1:0]   bimm_ext;

	ex_alu u_alu (
		.op     (in_req.op),
		.src_a  (in_req.src_a),
		.src_b  (in_req.src_b),
		.result (alu_result)
	);

	ex_mul u_mul (
		.clk     (clk),
		.reset   (reset),
		.start   (mul_start),
		.kind    (mul_kind),
		.a       (in_req.src_a),
		.b       (in_req.src_b),
		.busy    (mul_busy),
		.done    (mul_done),
		.product (mul_product)
	);

	always_comb begin
		is_mul = 1'b1;
		mul_kind = ex_op_pkg::mul_lo;
		case (in_req.op)
			ex_op_pkg::op_mul:   mul_kind = ex_op_pkg::mul_lo;
			ex_op_pkg::op_mulh:  mul_kind = ex_op_pkg::mul_hi_ss;
			ex_op_pkg::op_mulhu: mul_kind = ex_op_pkg::mul_hi_uu;
			ex_op_pkg::op_mulw:  mul_kind = ex_op_pkg::mul_word;
			default:             is_mul = 1'b0;
		endcase
	end

	assign in_ready = !mul_active && wr_ready;
	assign mul_start = in_valid && in_ready && is_mul && !mul_busy;
	assign wr_valid = mul_active ? (mul_done || mul_held) : (in_valid && !is_mul);

	always_ff @(posedge clk) begin
		if (reset) begin
			mul_active <= 1'b0;
			mul_held <= 1'b0;
		end else if (mul_start) begin
			mul_active <= 1'b1;
		end else if (mul_active && wr_valid && wr_ready) begin
			mul_active <= 1'b0;
			mul_held <= 1'b0;
		end else if (mul_done) begin
			mul_held <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_start) begin
			req_q <= in_req;
		end
	end

	assign cur = mul_active ? req_q : in_req;
	assign result = mul_active ? mul_product : alu_result;
	assign bimm_ext = {{(`EX_XLEN - `EX_BIMM_W - 1){cur.bimm[`EX_BIMM_W-1]}}, cur.bimm, 1'b0};

	always_comb begin
		wr_rsp.pc = cur.pc;
		wr_rsp.ins = cur.ins;
		wr_rsp.mem_w_en = cur.ctrl.mem_w_en;
		wr_rsp.wb_sel = cur.ctrl.wb_sel;
		wr_rsp.reg_w_en = cur.ctrl.reg_w_en;
		wr_rsp.rdest = cur.ctrl.rdest;
		wr_rsp.rt_data = cur.rt_data;
		wr_rsp.result = result;
		wr_rsp.branch_taken = cur.ctrl.branch && (result != '0);
		wr_rsp.branch_target = cur.pc + bimm_ext;
	end

endmodule

// ==== hw/ex_result_buf.sv ====
`timescale 1ns/1ps

module ex_result_buf (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   wr_valid,
	output logic                   wr_ready,
	input  ex_pipe_pkg::ex_rsp_t   wr_rsp,
	output logic                   rd_valid,
	input  logic                   rd_ready,
	output ex_pipe_pkg::ex_rsp_t   rd_rsp
);

	ex_pipe_pkg::ex_rsp_t  mem [0:1];
	logic                  wr_ptr;
	logic                  rd_ptr;
	logic [1:0]            count; // 0 to 2 entries
	logic                  push;
	logic                  pop;

	assign wr_ready = (count != 2'd2);
	assign rd_valid = (count != 2'd0);
	assign rd_rsp = mem[rd_ptr];

	assign push = wr_valid && wr_ready;
	assign pop = rd_valid && rd_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_rsp;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= !wr_ptr;
			end
			if (pop) begin
				rd_ptr <= !rd_ptr;
			end
			case ({push, pop})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

// ==== hw/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  ex_pipe_pkg::ex_req_t   in_req,
	output logic                   out_valid,
	input  logic                   out_ready,
	output ex_pipe_pkg::ex_rsp_t   out_rsp
);

	logic                  wr_valid;
	logic                  wr_ready;
	ex_pipe_pkg::ex_rsp_t  wr_rsp;

	ex_issue u_issue (
		.clk      (clk),
		.reset    (reset),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in_req   (in_req),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.wr_rsp   (wr_rsp)
	);

	// toward the memory stage
	ex_result_buf u_buf (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.wr_rsp   (wr_rsp),
		.rd_valid (out_valid),
		.rd_ready (out_ready),
		.rd_rsp   (out_rsp)
	);

endmodule

// ==== sim/ex_stage_tests.svh ====
`ifndef EX_STAGE_TESTS_SVH
`define EX_STAGE_TESTS_SVH

task automatic reset_state();
	test_name = "reset";
	reset = 1'b1;
	repeat (16) begin
		@(posedge clk);
		#10;
		check_value("out_valid", '0, out_valid);
		check_value("in_ready", 1, in_ready);
	end
	reset = 1'b0;
	@(posedge clk);
	#10;
	check_value("out_valid after reset", '0, out_valid);
	check_value("in_ready after reset", 1, in_ready);
endtask

// edge pair, random pair, equal pair
task automatic run_group(input int code, input logic [`EX_XLEN-1:0] edge_a,
	input logic [`EX_XLEN-1:0] edge_b, input logic branch);
	logic [`EX_XLEN-1:0] a;
	logic [`EX_XLEN-1:0] b;
	send_req(make_req(op_at(code), edge_a, edge_b, branch));
	a = rand64();
	b = rand64();
	send_req(make_req(op_at(code), a, b, branch));
	send_req(make_req(op_at(code), a, a, branch));
endtask

task automatic alu64_ops();
	int codes [8] = '{0, 2, 4, 6, 8, 9, 10, 17};
	test_name = "alu64";
	foreach (codes[i]) begin
		run_group(codes[i], '1, 64'h1, 1'b0);
		run_group(codes[i], 64'h8000_0000_0000_0000, 64'h3f, 1'b0);
	end
	drain();
endtask

task automatic word_compare_ops();
	int codes [11] = '{1, 3, 5, 7, 18, 11, 12, 13, 14, 15, 16};
	test_name = "word_cmp";
	foreach (codes[i]) begin
		run_group(codes[i], 64'h0000_0000_8000_0000, 64'h1f, 1'b0);
	end
	drain();
endtask

task automatic branch_fields();
	test_name = "branch";
	for (int code = 13; code <= 16; code++) begin
		run_group(code, '1, '0, 1'b1);
	end
	drain();
endtask

// response must show up, however long the multiply takes
task automatic mul_until_done(input int code, input logic [`EX_XLEN-1:0] a,
	input logic [`EX_XLEN-1:0] b);
	send_req(make_req(op_at(code), a, b, 1'b0));
	while (!out_valid) @(negedge clk);
	drain();
endtask

task automatic multiply_ops();
	logic [`EX_XLEN-1:0] a;
	logic [`EX_XLEN-1:0] b;
	test_name = "multiply";
	for (int code = 19; code <= 22; code++) begin
		mul_until_done(code, '1, '1);
		mul_until_done(code, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
		mul_until_done(code, 64'hffff_ffff_ffff_fffb, 64'h7);
		a = rand64();
		b = rand64();
		mul_until_done(code, a, b);
	end
endtask

task automatic backpressure_order();
	int                   codes [6] = '{17, 10, 20, 1, 13, 4};
	ex_pipe_pkg::ex_req_t more [6];
	logic [`EX_XLEN-1:0]  a;
	logic [`EX_XLEN-1:0]  b;
	int                   target;
	test_name = "backpressure";
	foreach (codes[i]) begin
		a = rand64();
		b = rand64();
		more[i] = make_req(op_at(codes[i]), a, b, 1'b0);
	end
	target = rx_count + 8;
	out_ready = 1'b0;
	a = rand64();
	b = rand64();
	send_req(make_req(ex_op_pkg::op_mulhu, a, b, 1'b0));
	send_req(make_req(ex_op_pkg::op_xor, b, a, 1'b0));
	check_value("in_ready with two buffered", '0, in_ready);
	fork
		begin
			foreach (more[i]) send_req(more[i]);
		end
		begin
			while (rx_count < target) begin
				@(posedge clk);
				#10;
				out_ready = ($random(seed) & 3) != 0;
			end
			out_ready = 1'b1;
		end
	join
	drain();
endtask

`endif

// ==== sim/ex_stage_tb.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage_tb;

	localparam int n_alu = 99; // ALU requests over all tests
	localparam int n_mul = 18;
	localparam int cycle_limit = 40 * n_alu + 80 * n_mul + 16;
	localparam int sh_w = $clog2(`EX_XLEN);
	localparam int shw_w = $clog2(`EX_WORD);

	logic                  clk;
	logic                  reset;
	logic                  in_valid;
	logic                  in_ready;
	ex_pipe_pkg::ex_req_t  in_req;
	logic                  out_valid;
	logic                  out_ready;
	ex_pipe_pkg::ex_rsp_t  out_rsp;

	ex_pipe_pkg::ex_rsp_t  exp_q [$]; // in acceptance order
	string                 test_name;
	integer                seed;
	int                    cycles;
	int                    rx_count;

	ex_stage uut (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rsp   (out_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			fail_run("timeout, the run went past its cycle limit");
		end
	end

	task automatic check_value(input string what, input logic [`EX_XLEN-1:0] expected,
		input logic [`EX_XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, what, expected,
				actual);
			fail_run("a response field did not match");
		end
	endtask

	function automatic logic [`EX_XLEN-1:0] sext_word(input logic [`EX_WORD-1:0] v);
		return {{(`EX_XLEN - `EX_WORD){v[`EX_WORD-1]}}, v};
	endfunction

	function automatic logic [`EX_XLEN-1:0] model_result(input ex_op_pkg::alu_op_t op,
		input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
		logic signed [`EX_XLEN-1:0] sa;
		logic signed [`EX_XLEN-1:0] sb;
		logic signed [`EX_WORD-1:0] sw;
		logic [2*`EX_XLEN-1:0]      wide_a;
		logic [2*`EX_XLEN-1:0]      wide_b;
		sa = a;
		sb = b;
		sw = a[`EX_WORD-1:0];
		wide_a = {{`EX_XLEN{a[`EX_XLEN-1]}}, a};
		wide_b = {{`EX_XLEN{b[`EX_XLEN-1]}}, b};
		case (op)
			ex_op_pkg::op_add:   return a + b;
			ex_op_pkg::op_addw:  return sext_word(a[`EX_WORD-1:0] + b[`EX_WORD-1:0]);
			ex_op_pkg::op_sll:   return a << b[sh_w-1:0];
			ex_op_pkg::op_sllw:  return sext_word(a[`EX_WORD-1:0] << b[shw_w-1:0]);
			ex_op_pkg::op_sra:   return sa >>> b[sh_w-1:0];
			ex_op_pkg::op_sraw:  return sext_word(sw >>> b[shw_w-1:0]);
			ex_op_pkg::op_srl:   return a >> b[sh_w-1:0];
			ex_op_pkg::op_srlw:  return sext_word(a[`EX_WORD-1:0] >> b[shw_w-1:0]);
			ex_op_pkg::op_and:   return a & b;
			ex_op_pkg::op_or:    return a | b;
			ex_op_pkg::op_xor:   return a ^ b;
			ex_op_pkg::op_slt:   return (sa < sb) ? 1 : 0;
			ex_op_pkg::op_sltu:  return (a < b) ? 1 : 0;
			ex_op_pkg::op_eq:    return (a == b) ? 1 : 0;
			ex_op_pkg::op_ne:    return (a != b) ? 1 : 0;
			ex_op_pkg::op_sge:   return (sa >= sb) ? 1 : 0;
			ex_op_pkg::op_sgeu:  return (a >= b) ? 1 : 0;
			ex_op_pkg::op_sub:   return a - b;
			ex_op_pkg::op_subw:  return sext_word(a[`EX_WORD-1:0] - b[`EX_WORD-1:0]);
			ex_op_pkg::op_mul:   return a * b;
			ex_op_pkg::op_mulh:  return (wide_a * wide_b) >> `EX_XLEN;
			ex_op_pkg::op_mulhu: return ({`EX_XLEN'(0), a} * {`EX_XLEN'(0), b}) >> `EX_XLEN;
			ex_op_pkg::op_mulw:  return sext_word(a[`EX_WORD-1:0] * b[`EX_WORD-1:0]);
			default:             return '0;
		endcase
	endfunction

	function automatic ex_pipe_pkg::ex_rsp_t expect_rsp(input ex_pipe_pkg::ex_req_t r);
		ex_pipe_pkg::ex_rsp_t       e;
		logic signed [`EX_XLEN-1:0] offset;
		offset = $signed(r.bimm);
		e.pc = r.pc;
		e.ins = r.ins;
		e.mem_w_en = r.ctrl.mem_w_en;
		e.wb_sel = r.ctrl.wb_sel;
		e.reg_w_en = r.ctrl.reg_w_en;
		e.rdest = r.ctrl.rdest;
		e.rt_data = r.rt_data;
		e.result = model_result(r.op, r.src_a, r.src_b);
		e.branch_taken = r.ctrl.branch && (e.result != 0);
		e.branch_target = r.pc + offset * 2; // halfword offset
		return e;
	endfunction

	function automatic logic [`EX_XLEN-1:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic ex_op_pkg::alu_op_t op_at(input int code);
		return ex_op_pkg::alu_op_t'(code);
	endfunction

	function automatic ex_pipe_pkg::ex_req_t make_req(input ex_op_pkg::alu_op_t op,
		input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b, input logic branch);
		ex_pipe_pkg::ex_req_t r;
		logic [31:0]          bits;
		r.pc = rand64() & ~64'h3;
		r.ins = $random(seed);
		r.op = op;
		r.src_a = a;
		r.src_b = b;
		r.rt_data = rand64();
		bits = $random(seed);
		r.bimm = bits[31:20];
		r.ctrl = bits[8:0];
		r.ctrl.branch = branch;
		return r;
	endfunction

	// entered and left 10 ns after a rising edge
	task automatic send_req(input ex_pipe_pkg::ex_req_t r);
		in_req = r;
		in_valid = 1'b1;
		while (!in_ready) begin
			@(posedge clk);
			#10;
		end
		@(posedge clk);
		exp_q.push_back(expect_rsp(r));
		#10;
		in_valid = 1'b0;
	endtask

	task automatic compare_rsp(input ex_pipe_pkg::ex_rsp_t e, input ex_pipe_pkg::ex_rsp_t got);
		check_value("result", e.result, got.result);
		check_value("branch_taken", e.branch_taken, got.branch_taken);
		check_value("branch_target", e.branch_target, got.branch_target);
		check_value("pc", e.pc, got.pc);
		check_value("ins", e.ins, got.ins);
		check_value("rt_data", e.rt_data, got.rt_data);
		check_value("ctrl", {e.mem_w_en, e.wb_sel, e.reg_w_en, e.rdest},
			{got.mem_w_en, got.wb_sel, got.reg_w_en, got.rdest});
	endtask

	// sampled mid-cycle before the accepting edge
	task automatic watch_responses();
		ex_pipe_pkg::ex_rsp_t e;
		forever begin
			@(negedge clk);
			if (!reset && out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					fail_run("a response came out with no request pending");
				end else begin
					e = exp_q.pop_front();
					compare_rsp(e, out_rsp);
					rx_count++;
				end
			end
		end
	endtask

	task automatic drain();
		out_ready = 1'b1;
		do @(posedge clk); while (exp_q.size() != 0);
		#10;
	endtask

	initial begin
		seed = 32'h034e_7283;
		cycles = 0;
		rx_count = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b1;
		test_name = "init";
		fork
			watch_responses();
		join_none
		reset_state();
		alu64_ops();
		word_compare_ops();
		branch_fields();
		multiply_ops();
		backpressure_order();
		if (exp_q.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			fail_run("some responses never came out");
		end
	end

	`include "ex_stage_tests.svh"

endmodule

// ==== ex_stage.f ====
+incdir+hw
+incdir+sim
hw/ex_op_pkg.sv
hw/ex_pipe_pkg.sv
hw/ex_alu.sv
hw/ex_mul.sv
hw/ex_issue.sv
hw/ex_result_buf.sv
hw/ex_stage.sv
sim/ex_stage_tb.sv
